// File: logic/fleet_pkg.sv
`default_nettype none

package fleet_pkg;

    // ==========================================================
    // Board coordinates and cell contents
    // ==========================================================

    // Row or column index. Three bits cover boards up to 8 by 8.
    typedef logic [2:0] coord_t;

    // Ship code. Zero is an empty cell, code k is the ship of length k.
    typedef logic [2:0] ship_t;

    // ==========================================================
    // Commands, results and game phase
    // ==========================================================

    // CMD_BAD is a place or fire whose coordinates fall off the grid.
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_CLEAR = 3'd1,
        CMD_PLACE = 3'd2,
        CMD_FIRE  = 3'd3,
        CMD_BAD   = 3'd4
    } cmd_kind_e;

    typedef enum logic [2:0] {
        RES_PLACED   = 3'd0,
        RES_REJECTED = 3'd1,
        RES_MISS     = 3'd2,
        RES_HIT      = 3'd3,
        RES_SUNK     = 3'd4,
        RES_REPEAT   = 3'd5
    } result_e;

    typedef enum logic {
        PH_PLACING = 1'b0,
        PH_BATTLE  = 1'b1
    } phase_e;

endpackage

`default_nettype wire

// File: logic/fleet_cmd_if.sv
`timescale 1ns/10ps
`default_nettype none

// Decoded command, one stage after the input pins.
interface fleet_cmd_if;
    import fleet_pkg::*;

    logic      valid;
    logic      enable;
    cmd_kind_e kind;
    coord_t    row;
    coord_t    col;

    modport src (
        output valid, enable, kind, row, col
    );

    modport dst (
        input valid, enable, kind, row, col
    );

endinterface

`default_nettype wire

// File: logic/fleet_upd_if.sv
`timescale 1ns/10ps
`default_nettype none

// Decided update, one stage before the cell store.
interface fleet_upd_if;
    import fleet_pkg::*;

    logic      valid;
    cmd_kind_e kind;
    coord_t    row;
    coord_t    col;
    ship_t     ship;
    result_e   result;
    logic      last;

    modport src (
        output valid, kind, row, col, ship, result, last
    );

    modport dst (
        input valid, kind, row, col, ship, result, last
    );

endinterface

`default_nettype wire

// File: logic/cmd_decode.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_decode #(
    parameter int BOARD_N = 5
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             place_enable,
    input  logic             place,
    input  logic             fire,
    input  fleet_pkg::coord_t row,
    input  fleet_pkg::coord_t col,
    fleet_cmd_if.src         cmd
);

    import fleet_pkg::*;

    logic      enable_q;
    logic      in_range;
    cmd_kind_e kind_d;

    // A restart edge wins over any strobe at the same edge.
    // Fire wins over place.
    always_comb begin
        in_range = (int'(row) < BOARD_N) && (int'(col) < BOARD_N);
        if (place_enable && !enable_q) begin
            kind_d = CMD_CLEAR;
        end else if (fire || place) begin
            if (!in_range) begin
                kind_d = CMD_BAD;
            end else if (fire) begin
                kind_d = CMD_FIRE;
            end else begin
                kind_d = CMD_PLACE;
            end
        end else begin
            kind_d = CMD_NONE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable_q   <= 1'b0;
            cmd.enable <= 1'b0;
            cmd.valid  <= 1'b0;
            cmd.kind   <= CMD_NONE;
        end else begin
            enable_q   <= place_enable;
            cmd.enable <= place_enable;
            cmd.valid  <= (kind_d != CMD_NONE);
            cmd.kind   <= kind_d;
        end
    end

    always_ff @(posedge clk) begin
        cmd.row <= row;
        cmd.col <= col;
    end

endmodule

`default_nettype wire

// File: logic/fleet_place.sv
`timescale 1ns/10ps
`default_nettype none

module fleet_place #(
    parameter int BOARD_N    = 5,
    parameter int FLEET_SIZE = 5
) (
    input  logic     clk,
    input  logic     arst_n,
    fleet_cmd_if.dst cmd,
    fleet_upd_if.src upd
);

    import fleet_pkg::*;

    phase_e                           phase;
    ship_t                            ships_left;
    logic [BOARD_N-1:0][BOARD_N-1:0]  occ;
    logic [BOARD_N-1:0][BOARD_N-1:0]  shot;

    logic [BOARD_N-1:0] span;
    logic               fits;
    result_e            res_d;
    cmd_kind_e          kind_d;
    logic               last_d;

    // ==========================================================
    // Placement check
    // ==========================================================

    // The ship ends at col and runs ships_left cells toward column 0.
    always_comb begin
        for (int c = 0; c < BOARD_N; c++) begin
            span[c] = (c <= int'(cmd.col)) && (c > int'(cmd.col) - int'(ships_left));
        end
        fits = (int'(cmd.col) >= int'(ships_left) - 1) && ((occ[cmd.row] & span) == '0);
    end

    // ==========================================================
    // Decision
    // ==========================================================

    always_comb begin
        res_d  = RES_REJECTED;
        kind_d = cmd.kind;
        last_d = 1'b0;
        case (cmd.kind)
            CMD_PLACE: begin
                if (phase == PH_PLACING && cmd.enable && fits) begin
                    res_d  = RES_PLACED;
                    last_d = (ships_left == ship_t'(1));
                end
            end
            CMD_FIRE: begin
                if (phase == PH_BATTLE) begin
                    if (shot[cmd.row][cmd.col]) begin
                        res_d = RES_REPEAT;
                    end else if (occ[cmd.row][cmd.col]) begin
                        res_d = RES_HIT;
                    end else begin
                        res_d = RES_MISS;
                    end
                end
            end
            CMD_BAD: begin
                // Reported as the command the phase expects.
                kind_d = (phase == PH_BATTLE) ? CMD_FIRE : CMD_PLACE;
            end
            default: begin
            end
        endcase
    end

    // ==========================================================
    // Phase, counter and maps
    // ==========================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase      <= PH_PLACING;
            ships_left <= ship_t'(FLEET_SIZE);
            occ        <= '0;
            shot       <= '0;
            upd.valid  <= 1'b0;
        end else begin
            upd.valid <= cmd.valid;
            if (cmd.valid) begin
                if (cmd.kind == CMD_CLEAR) begin
                    phase      <= PH_PLACING;
                    ships_left <= ship_t'(FLEET_SIZE);
                    occ        <= '0;
                    shot       <= '0;
                end else if (res_d == RES_PLACED) begin
                    occ[cmd.row] <= occ[cmd.row] | span;
                    ships_left   <= ships_left - ship_t'(1);
                    if (last_d) begin
                        phase <= PH_BATTLE;
                    end
                end else if (res_d == RES_HIT || res_d == RES_MISS) begin
                    shot[cmd.row][cmd.col] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        upd.kind   <= kind_d;
        upd.row    <= cmd.row;
        upd.col    <= cmd.col;
        upd.ship   <= ships_left;
        upd.result <= res_d;
        upd.last   <= last_d;
    end

endmodule

`default_nettype wire

// File: logic/board_grid.sv
`timescale 1ns/10ps
`default_nettype none

module board_grid #(
    parameter int BOARD_N    = 5,
    parameter int FLEET_SIZE = 5
) (
    input  logic               clk,
    input  logic               arst_n,
    fleet_upd_if.dst           upd,
    output logic               result_valid,
    output fleet_pkg::result_e result,
    output fleet_pkg::ship_t   result_ship,
    output logic               fleet_placed,
    output logic               all_sunk,
    input  fleet_pkg::coord_t  rd_row,
    input  fleet_pkg::coord_t  rd_col,
    output fleet_pkg::ship_t   rd_code
);

    import fleet_pkg::*;

    // Cells of the whole fleet, 1 + 2 + ... + FLEET_SIZE.
    localparam int TOTAL_CELLS = FLEET_SIZE * (FLEET_SIZE + 1) / 2;
    localparam int TOTAL_W     = $clog2(TOTAL_CELLS + 1);

    typedef logic [TOTAL_W-1:0] total_t;

    ship_t  code [BOARD_N][BOARD_N];
    ship_t  hits_left [1:FLEET_SIZE];
    total_t total_left;

    logic    tgt_ok;
    ship_t   tgt;
    logic    sink;
    ship_t   ship_d;
    logic [BOARD_N-1:0] span;

    // ==========================================================
    // Target cell lookup
    // ==========================================================

    always_comb begin
        tgt_ok = (int'(upd.row) < BOARD_N) && (int'(upd.col) < BOARD_N);
        tgt    = tgt_ok ? code[upd.row][upd.col] : '0;
        sink   = (upd.result == RES_HIT) && (hits_left[tgt] == ship_t'(1));
        for (int c = 0; c < BOARD_N; c++) begin
            span[c] = (c <= int'(upd.col)) && (c > int'(upd.col) - int'(upd.ship));
        end
        case (upd.result)
            RES_PLACED:   ship_d = upd.ship;
            RES_REJECTED: ship_d = '0;
            default:      ship_d = tgt;
        endcase
    end

    // ==========================================================
    // Cell codes, hit counts and flags
    // ==========================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            fleet_placed <= 1'b0;
            all_sunk     <= 1'b0;
            total_left   <= '0;
            for (int r = 0; r < BOARD_N; r++) begin
                for (int c = 0; c < BOARD_N; c++) begin
                    code[r][c] <= '0;
                end
            end
            for (int k = 1; k <= FLEET_SIZE; k++) begin
                hits_left[k] <= '0;
            end
        end else begin
            result_valid <= upd.valid && (upd.kind != CMD_CLEAR);
            if (upd.valid) begin
                if (upd.kind == CMD_CLEAR) begin
                    fleet_placed <= 1'b0;
                    all_sunk     <= 1'b0;
                    total_left   <= '0;
                    for (int r = 0; r < BOARD_N; r++) begin
                        for (int c = 0; c < BOARD_N; c++) begin
                            code[r][c] <= '0;
                        end
                    end
                    for (int k = 1; k <= FLEET_SIZE; k++) begin
                        hits_left[k] <= '0;
                    end
                end else if (upd.result == RES_PLACED) begin
                    for (int c = 0; c < BOARD_N; c++) begin
                        if (span[c]) begin
                            code[upd.row][c] <= upd.ship;
                        end
                    end
                    hits_left[upd.ship] <= upd.ship;
                    total_left          <= total_left + total_t'(upd.ship);
                    if (upd.last) begin
                        fleet_placed <= 1'b1;
                    end
                end else if (upd.result == RES_HIT) begin
                    hits_left[tgt] <= hits_left[tgt] - ship_t'(1);
                    total_left     <= total_left - total_t'(1);
                    // Last unhit cell of the fleet.
                    if (total_left == total_t'(1)) begin
                        all_sunk <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        result      <= sink ? RES_SUNK : upd.result;
        result_ship <= ship_d;
    end

    // Display read port.
    assign rd_code = ((int'(rd_row) < BOARD_N) && (int'(rd_col) < BOARD_N))
                   ? code[rd_row][rd_col] : '0;

endmodule

`default_nettype wire

// File: logic/fleet_board_top.sv
`timescale 1ns/10ps
`default_nettype none

module fleet_board_top #(
    parameter int BOARD_N    = 5,
    parameter int FLEET_SIZE = 5
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               place_enable,
    input  logic               place,
    input  logic               fire,
    input  fleet_pkg::coord_t  row,
    input  fleet_pkg::coord_t  col,
    output logic               result_valid,
    output fleet_pkg::result_e result,
    output fleet_pkg::ship_t   result_ship,
    output logic               fleet_placed,
    output logic               all_sunk,
    input  fleet_pkg::coord_t  rd_row,
    input  fleet_pkg::coord_t  rd_col,
    output fleet_pkg::ship_t   rd_code
);

    fleet_cmd_if i_cmd_if ();
    fleet_upd_if i_upd_if ();

    // Stage 1. Decode.
    cmd_decode #(
        .BOARD_N (BOARD_N)
    ) i_cmd_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .place_enable (place_enable),
        .place        (place),
        .fire         (fire),
        .row          (row),
        .col          (col),
        .cmd          (i_cmd_if.src)
    );

    // Stage 2. Decide.
    fleet_place #(
        .BOARD_N    (BOARD_N),
        .FLEET_SIZE (FLEET_SIZE)
    ) i_fleet_place (
        .clk    (clk),
        .arst_n (arst_n),
        .cmd    (i_cmd_if.dst),
        .upd    (i_upd_if.src)
    );

    // Stage 3. Store and report.
    board_grid #(
        .BOARD_N    (BOARD_N),
        .FLEET_SIZE (FLEET_SIZE)
    ) i_board_grid (
        .clk          (clk),
        .arst_n       (arst_n),
        .upd          (i_upd_if.dst),
        .result_valid (result_valid),
        .result       (result),
        .result_ship  (result_ship),
        .fleet_placed (fleet_placed),
        .all_sunk     (all_sunk),
        .rd_row       (rd_row),
        .rd_col       (rd_col),
        .rd_code      (rd_code)
    );

endmodule

`default_nettype wire

// File: dv/fleet_board_sva.sv
`timescale 1ns/10ps
`default_nettype none

module fleet_board_sva (
    input logic clk,
    input logic arst_n,
    input logic place_enable,
    input logic place,
    input logic fire,
    input logic result_valid,
    input logic fleet_placed,
    input logic all_sunk
);

    logic enable_q;
    logic clr;
    logic strobe;
    int   fail_count;

    initial fail_count = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable_q <= 1'b0;
        end else begin
            enable_q <= place_enable;
        end
    end

    // A restart edge swallows any strobe sampled with it.
    assign clr    = place_enable && !enable_q;
    assign strobe = (place || fire) && !clr;

    // ==========================================================
    // Two cycles of latency, seen three sampling edges later
    // ==========================================================

    a_strobe_result: assert property (@(posedge clk) disable iff (!arst_n)
        strobe |-> ##3 result_valid)
    else begin
        fail_count++;
        $error("result_valid missing three edges after a strobe");
    end

    a_result_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid |-> $past(strobe, 3))
    else begin
        fail_count++;
        $error("result_valid without a matching strobe");
    end

    a_clear_silent: assert property (@(posedge clk) disable iff (!arst_n)
        clr |-> ##3 !result_valid)
    else begin
        fail_count++;
        $error("result_valid raised for a board clear");
    end

    // ==========================================================
    // Flags
    // ==========================================================

    a_placed_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(fleet_placed) |-> $past(clr, 3))
    else begin
        fail_count++;
        $error("fleet_placed fell without a rising place_enable");
    end

    a_sunk_placed: assert property (@(posedge clk) disable iff (!arst_n)
        all_sunk |-> fleet_placed)
    else begin
        fail_count++;
        $error("all_sunk high while fleet_placed is low");
    end

endmodule

bind fleet_board_top fleet_board_sva i_fleet_board_sva (
    .clk          (clk),
    .arst_n       (arst_n),
    .place_enable (place_enable),
    .place        (place),
    .fire         (fire),
    .result_valid (result_valid),
    .fleet_placed (fleet_placed),
    .all_sunk     (all_sunk)
);

`default_nettype wire

// File: dv/fleet_board_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fleet_board_tb;

    import fleet_pkg::*;

    localparam int BOARD_N    = 5;
    localparam int FLEET_SIZE = 5;
    localparam int RAND_SHOTS = 40;
    // Placing commands, random shots, the full sweep and the final placement.
    localparam int NUM_CMDS   = 15 + RAND_SHOTS + BOARD_N * BOARD_N;
    // Reset, restarts, drains and grid reads.
    localparam int MARGIN     = 300;

    typedef struct packed {
        result_e res;
        ship_t   ship;
        logic    placed;
        logic    sunk;
    } exp_t;

    logic    clk;
    logic    arst_n;
    logic    place_enable;
    logic    place;
    logic    fire;
    coord_t  row;
    coord_t  col;
    logic    result_valid;
    result_e result;
    ship_t   result_ship;
    logic    fleet_placed;
    logic    all_sunk;
    coord_t  rd_row;
    coord_t  rd_col;
    ship_t   rd_code;

    // Reference model.
    ship_t       code_m [BOARD_N][BOARD_N];
    logic        shot_m [BOARD_N][BOARD_N];
    int          hits_m [1:FLEET_SIZE];
    int          left_m;
    int          total_m;
    logic        battle_m;
    logic        placed_m;
    logic        sunk_m;
    exp_t        exp_q [$];
    int          errors;
    logic [31:0] rng;

    fleet_board_top #(
        .BOARD_N    (BOARD_N),
        .FLEET_SIZE (FLEET_SIZE)
    ) i_fleet_board_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .place_enable (place_enable),
        .place        (place),
        .fire         (fire),
        .row          (row),
        .col          (col),
        .result_valid (result_valid),
        .result       (result),
        .result_ship  (result_ship),
        .fleet_placed (fleet_placed),
        .all_sunk     (all_sunk),
        .rd_row       (rd_row),
        .rd_col       (rd_col),
        .rd_code      (rd_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (NUM_CMDS * 4 + MARGIN) @(posedge clk);
        $display("Timeout: the run did not finish within the expected number of cycles.");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic clear_model();
        for (int r = 0; r < BOARD_N; r++) begin
            for (int c = 0; c < BOARD_N; c++) begin
                code_m[r][c] = '0;
                shot_m[r][c] = 1'b0;
            end
        end
        for (int k = 1; k <= FLEET_SIZE; k++) begin
            hits_m[k] = 0;
        end
        left_m   = FLEET_SIZE;
        total_m  = 0;
        battle_m = 1'b0;
        placed_m = 1'b0;
        sunk_m   = 1'b0;
    endtask

    // ==========================================================
    // Expected result of one command
    // ==========================================================

    task automatic predict(input logic is_fire, input int r, input int c);
        exp_t e;
        logic free;
        int   k;
        e.res  = RES_REJECTED;
        e.ship = '0;
        if (r < BOARD_N && c < BOARD_N) begin
            if (is_fire && battle_m) begin
                k      = int'(code_m[r][c]);
                e.ship = code_m[r][c];
                if (shot_m[r][c]) begin
                    e.res = RES_REPEAT;
                end else if (k == 0) begin
                    shot_m[r][c] = 1'b1;
                    e.res        = RES_MISS;
                end else begin
                    shot_m[r][c] = 1'b1;
                    hits_m[k]--;
                    total_m--;
                    e.res  = (hits_m[k] == 0) ? RES_SUNK : RES_HIT;
                    sunk_m = sunk_m || (total_m == 0);
                end
            end else if (!is_fire && !battle_m && place_enable && c >= left_m - 1) begin
                free = 1'b1;
                for (int i = c - left_m + 1; i <= c; i++) begin
                    if (code_m[r][i] != '0) begin
                        free = 1'b0;
                    end
                end
                if (free) begin
                    for (int i = c - left_m + 1; i <= c; i++) begin
                        code_m[r][i] = ship_t'(left_m);
                    end
                    hits_m[left_m] = left_m;
                    total_m        = total_m + left_m;
                    e.res          = RES_PLACED;
                    e.ship         = ship_t'(left_m);
                    left_m--;
                    if (left_m == 0) begin
                        battle_m = 1'b1;
                        placed_m = 1'b1;
                    end
                end
            end
        end
        e.placed = placed_m;
        e.sunk   = sunk_m;
        exp_q.push_back(e);
    endtask

    // Drives one strobe for one cycle, starting 2 ns after an edge.
    task automatic send(input logic is_fire, input int r, input int c);
        fire  = is_fire;
        place = !is_fire;
        row   = coord_t'(r);
        col   = coord_t'(c);
        predict(is_fire, r, c);
        @(posedge clk);
        #2;
        fire  = 1'b0;
        place = 1'b0;
    endtask

    task automatic drain();
        int wait_cycles;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 10) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Missing results: %0d expected results never arrived.", exp_q.size());
            exp_q.delete();
        end
        @(posedge clk);
        #2;
    endtask

    // One cell per cycle, read back 1 ns after the address is driven.
    task automatic check_grid();
        for (int r = 0; r < BOARD_N; r++) begin
            for (int c = 0; c < BOARD_N; c++) begin
                rd_row = coord_t'(r);
                rd_col = coord_t'(c);
                #1;
                assert (rd_code == code_m[r][c]) else begin
                    errors++;
                    $display("FAILED %0t: rd_code at (%0d,%0d) got %0d expected %0d",
                             $time, r, c, rd_code, code_m[r][c]);
                end
                @(posedge clk);
                #2;
            end
        end
    endtask

    task automatic restart();
        place_enable = 1'b0;
        @(posedge clk);
        #2;
        place_enable = 1'b1;
        @(posedge clk);
        #2;
        clear_model();
        // The clear reaches the grid two edges after decode.
        repeat (3) @(posedge clk);
        #2;
        check_grid();
        assert (!fleet_placed) else begin
            errors++;
            $display("FAILED %0t: fleet_placed got 1 expected 0", $time);
        end
        assert (!all_sunk) else begin
            errors++;
            $display("FAILED %0t: all_sunk got 1 expected 0", $time);
        end
    endtask

    // ==========================================================
    // Result checker
    // ==========================================================

    always @(negedge clk) begin : check_results
        exp_t e;
        if (arst_n && result_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected result at %0t with no command pending.", $time);
            end else begin
                e = exp_q.pop_front();
                assert (result == e.res) else begin
                    errors++;
                    $display("FAILED %0t: result got %s expected %s",
                             $time, result.name(), e.res.name());
                end
                assert (result_ship == e.ship) else begin
                    errors++;
                    $display("FAILED %0t: result_ship got %0d expected %0d",
                             $time, result_ship, e.ship);
                end
                assert (fleet_placed == e.placed) else begin
                    errors++;
                    $display("FAILED %0t: fleet_placed got %0b expected %0b",
                             $time, fleet_placed, e.placed);
                end
                assert (all_sunk == e.sunk) else begin
                    errors++;
                    $display("FAILED %0t: all_sunk got %0b expected %0b",
                             $time, all_sunk, e.sunk);
                end
            end
        end
    end

    initial begin
        errors       = 0;
        rng          = 32'h51ba_979a;
        arst_n       = 1'b0;
        place_enable = 1'b0;
        place        = 1'b0;
        fire         = 1'b0;
        row          = '0;
        col          = '0;
        rd_row       = '0;
        rd_col       = '0;
        clear_model();
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(posedge clk);
        #2;
        restart();

        // Placing, with rejected commands issued back to back.
        send(1'b0, 0, 3);
        send(1'b1, 1, 1);
        send(1'b0, 5, 4);
        send(1'b0, 0, 4);
        send(1'b0, 0, 4);
        send(1'b0, 1, 3);
        send(1'b0, 2, 1);
        send(1'b0, 1, 7);
        send(1'b0, 2, 4);
        send(1'b0, 3, 1);
        send(1'b0, 3, 1);
        send(1'b0, 4, 2);
        // Battle has started.
        send(1'b0, 4, 4);
        send(1'b1, 6, 0);
        drain();
        check_grid();

        for (int i = 0; i < RAND_SHOTS; i++) begin
            rng = xorshift(rng);
            send(1'b1, int'(rng[7:0]) % BOARD_N, int'(rng[15:8]) % BOARD_N);
        end
        // A full sweep sinks whatever is left.
        for (int r = 0; r < BOARD_N; r++) begin
            for (int c = 0; c < BOARD_N; c++) begin
                send(1'b1, r, c);
            end
        end
        drain();

        restart();
        send(1'b0, 2, 4);
        drain();
        check_grid();

        $display("Errors: %0d from checks, %0d from assertions",
                 errors, i_fleet_board_top.i_fleet_board_sva.fail_count);
        if (errors == 0 && i_fleet_board_top.i_fleet_board_sva.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/fleet_pkg.sv
logic/fleet_cmd_if.sv
logic/fleet_upd_if.sv
logic/cmd_decode.sv
logic/fleet_place.sv
logic/board_grid.sv
logic/fleet_board_top.sv
dv/fleet_board_sva.sv
dv/fleet_board_tb.sv

// File: Makefile
SIM       ?= verilator
TOP       ?= fleet_board_tb
FILELIST  ?= vlog.f
SIM_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
